//--- Bender.yml
package:
  name: phy_ft

sources:
  - common/phy_link_pkg.sv
  - common/mdio_pkg.sv
  - src/mdio_shifter.sv
  - src/gmii_port_mux.sv
  - phy_ft/phy_ft_ctrl.sv
  - phy_ft/phy_ft.sv
  - target: test
    files:
      - verif/mdio_phy_model.sv
      - verif/phy_ft_tb.sv

//--- common/mdio_pkg.sv
package mdio_pkg;

	localparam logic [1:0] ST_CL22  = 2'b01;
	localparam logic [1:0] OP_WRITE = 2'b01;
	localparam logic [1:0] OP_READ  = 2'b10;
	localparam logic [1:0] TA_BITS  = 2'b10; // Only driven on writes

	localparam logic [4:0] REG_CTRL = 5'd0;
	localparam logic [4:0] REG_PSSR = 5'd17; // PHY specific status
	localparam logic [4:0] REG_EPCR = 5'd20; // Extended PHY specific control

	localparam logic [15:0] EPCR_DELAY_SET = 16'h0082; // RX and TX clock delay
	localparam logic [15:0] CTRL_RESET_SET = 16'h8000; // Soft reset

	// Sent MSB first, after the preamble
	typedef struct packed {
		logic [1:0]  st;
		logic [1:0]  op;
		logic [4:0]  phy_addr;
		logic [4:0]  reg_addr;
		logic [1:0]  ta;
		logic [15:0] data;
	} mdio_frame_t;

endpackage

//--- common/phy_link_pkg.sv
package phy_link_pkg;

	typedef enum logic [1:0] {
		SPEED_10   = 2'b00,
		SPEED_100  = 2'b01,
		SPEED_1000 = 2'b10
	} speed_e;

	// Per-PHY view, decoded from register 17
	typedef struct packed {
		logic   up;
		speed_e speed;
		logic   duplex;
	} phy_status_t;

	typedef struct packed {
		logic   up;
		speed_e speed;
		logic   duplex;
		logic   active_port;
	} link_state_t;

	typedef struct packed {
		logic [7:0] dat;
		logic       dv;
		logic       er;
		logic       crs;
		logic       col;
	} gmii_rx_t;

	typedef struct packed {
		logic [7:0] dat;
		logic       en;
		logic       er;
	} gmii_tx_t;

endpackage

//--- phy_ft.f
common/phy_link_pkg.sv
common/mdio_pkg.sv
src/mdio_shifter.sv
src/gmii_port_mux.sv
phy_ft/phy_ft_ctrl.sv
phy_ft/phy_ft.sv
verif/mdio_phy_model.sv
verif/phy_ft_tb.sv

//--- phy_ft/phy_ft.sv
`timescale 1ns/1ps

module phy_ft import phy_link_pkg::*, mdio_pkg::*; #(
	parameter logic [4:0] PHY_ADDR    = 5'd0,
	parameter int         MDC_DIV     = 8,
	parameter int         INIT_CYCLES = 750000,
	parameter bit         INIT_EPCR   = 1'b1
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        reset_in_i,
	output link_state_t link_o,
	output logic        link_change_o,
	output phy_status_t phy0_status_o,
	output phy_status_t phy1_status_o,
	// MAC side
	output gmii_rx_t    mac_rx_o,
	input  gmii_tx_t    mac_tx_i,
	output logic        mac_rxclk_o,
	input  logic        mac_txclk_i,
	// Host MDIO master
	input  logic        mdc_i,
	input  logic        mdio_o_i,
	input  logic        mdio_oe_i,
	input  logic        mdio_req_i,
	output logic        mdio_gnt_o,
	output logic        mdio_i_o,
	output logic        irq_o,
	// PHY 0
	input  gmii_rx_t    phy0_rx_i,
	output gmii_tx_t    phy0_tx_o,
	input  logic        phy0_rxclk_i,
	output logic        phy0_txclk_o,
	output logic        phy0_mdc_o,
	input  logic        phy0_mdio_i,
	output logic        phy0_mdio_o,
	output logic        phy0_mdio_oe_o,
	input  logic        phy0_int_i,
	output logic        phy0_reset_o,
	// PHY 1
	input  gmii_rx_t    phy1_rx_i,
	output gmii_tx_t    phy1_tx_o,
	input  logic        phy1_rxclk_i,
	output logic        phy1_txclk_o,
	output logic        phy1_mdc_o,
	input  logic        phy1_mdio_i,
	output logic        phy1_mdio_o,
	output logic        phy1_mdio_oe_o,
	input  logic        phy1_int_i,
	output logic        phy1_reset_o
);

	logic        rst_all;
	mdio_frame_t frame;
	logic        start;
	logic        p0_done, p1_done;
	logic [15:0] p0_rd_data, p1_rd_data;
	logic        p0_mdc, p0_mdio_o, p0_mdio_oe;
	logic        p1_mdc, p1_mdio_o, p1_mdio_oe;

	assign rst_all      = reset | reset_in_i;
	assign phy0_reset_o = rst_all;
	assign phy1_reset_o = rst_all;

	phy_ft_ctrl #(
		.PHY_ADDR(PHY_ADDR), .INIT_CYCLES(INIT_CYCLES), .INIT_EPCR(INIT_EPCR)
	) ctrl_i (
		.clk(clk), .reset(rst_all),
		.mdio_req_i(mdio_req_i), .mdio_gnt_o(mdio_gnt_o),
		.frame_o(frame), .start_o(start),
		.p0_done_i(p0_done), .p1_done_i(p1_done),
		.p0_rd_data_i(p0_rd_data), .p1_rd_data_i(p1_rd_data),
		.link_o(link_o), .link_change_o(link_change_o),
		.phy0_status_o(phy0_status_o), .phy1_status_o(phy1_status_o)
	);

	mdio_shifter #(.MDC_DIV(MDC_DIV)) p0_shift_i (
		.clk(clk), .reset(rst_all),
		.start_i(start), .frame_i(frame), .done_o(p0_done), .rd_data_o(p0_rd_data),
		.mdc_o(p0_mdc), .mdio_i(phy0_mdio_i), .mdio_o(p0_mdio_o), .mdio_oe_o(p0_mdio_oe)
	);

	mdio_shifter #(.MDC_DIV(MDC_DIV)) p1_shift_i (
		.clk(clk), .reset(rst_all),
		.start_i(start), .frame_i(frame), .done_o(p1_done), .rd_data_o(p1_rd_data),
		.mdc_o(p1_mdc), .mdio_i(phy1_mdio_i), .mdio_o(p1_mdio_o), .mdio_oe_o(p1_mdio_oe)
	);

	// Host owns both buses while granted
	assign phy0_mdc_o     = mdio_gnt_o ? mdc_i : p0_mdc;
	assign phy0_mdio_o    = mdio_gnt_o ? mdio_o_i : p0_mdio_o;
	assign phy0_mdio_oe_o = mdio_gnt_o ? mdio_oe_i : p0_mdio_oe;
	assign phy1_mdc_o     = mdio_gnt_o ? mdc_i : p1_mdc;
	assign phy1_mdio_o    = mdio_gnt_o ? mdio_o_i : p1_mdio_o;
	assign phy1_mdio_oe_o = mdio_gnt_o ? mdio_oe_i : p1_mdio_oe;

	assign mdio_i_o = link_o.active_port ? phy1_mdio_i : phy0_mdio_i;
	assign irq_o    = link_o.active_port ? phy1_int_i : phy0_int_i;

	gmii_port_mux mux_i (
		.select_i(link_o.active_port),
		.phy0_rx_i(phy0_rx_i), .phy1_rx_i(phy1_rx_i), .mac_rx_o(mac_rx_o),
		.mac_tx_i(mac_tx_i), .phy0_tx_o(phy0_tx_o), .phy1_tx_o(phy1_tx_o),
		.phy0_rxclk_i(phy0_rxclk_i), .phy1_rxclk_i(phy1_rxclk_i),
		.mac_rxclk_o(mac_rxclk_o), .mac_txclk_i(mac_txclk_i),
		.phy0_txclk_o(phy0_txclk_o), .phy1_txclk_o(phy1_txclk_o)
	);

endmodule

//--- phy_ft/phy_ft_ctrl.sv
`timescale 1ns/1ps

module phy_ft_ctrl import phy_link_pkg::*, mdio_pkg::*; #(
	parameter logic [4:0] PHY_ADDR    = 5'd0,
	parameter int         INIT_CYCLES = 1000,
	parameter bit         INIT_EPCR   = 1'b1
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        mdio_req_i,
	output logic        mdio_gnt_o,
	output mdio_frame_t frame_o,
	output logic        start_o,
	input  logic        p0_done_i,
	input  logic        p1_done_i,
	input  logic [15:0] p0_rd_data_i,
	input  logic [15:0] p1_rd_data_i,
	output link_state_t link_o,
	output logic        link_change_o,
	output phy_status_t phy0_status_o,
	output phy_status_t phy1_status_o
);

	localparam int TMR_W = $clog2(INIT_CYCLES + 1);

	typedef enum logic [3:0] {
		S_INIT, S_REPCR_STRB, S_REPCR_WAIT, S_WEPCR_STRB, S_WEPCR_WAIT,
		S_RCTRL_STRB, S_RCTRL_WAIT, S_WCTRL_STRB, S_WCTRL_WAIT,
		S_IDLE, S_HOST_ACCESS, S_READ_STRB, S_READ_WAIT, S_READ_LATCH, S_SELECT
	} state_e;

	state_e           state;
	state_e           state_next;
	logic [TMR_W-1:0] init_timer;
	logic             req_meta;
	logic             req_sync;
	logic             new_strobe;

	function automatic mdio_frame_t make_frame(logic [1:0] op, logic [4:0] reg_addr,
			logic [15:0] data);
		mdio_frame_t f;
		f.st       = ST_CL22;
		f.op       = op;
		f.phy_addr = PHY_ADDR;
		f.reg_addr = reg_addr;
		f.ta       = TA_BITS;
		f.data     = data;
		return f;
	endfunction

	function automatic phy_status_t decode_pssr(logic [15:0] pssr);
		phy_status_t s;
		s.up     = pssr[10];
		s.speed  = speed_e'(pssr[15:14]);
		s.duplex = pssr[13];
		return s;
	endfunction

	function automatic link_state_t to_link(phy_status_t s, logic port);
		link_state_t l;
		l.up          = 1'b1;
		l.speed       = s.speed;
		l.duplex      = s.duplex;
		l.active_port = port;
		return l;
	endfunction

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			req_meta <= 1'b0;
			req_sync <= 1'b0;
			state    <= S_INIT;
		end else begin
			req_meta <= mdio_req_i;
			req_sync <= req_meta;
			state    <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			S_INIT:
				if (init_timer == TMR_W'(INIT_CYCLES))
					state_next = INIT_EPCR ? S_REPCR_STRB : S_IDLE;
			S_REPCR_STRB:
				if (!p0_done_i)
					state_next = S_REPCR_WAIT;
			S_REPCR_WAIT:
				if (p0_done_i)
					state_next = S_WEPCR_STRB;
			S_WEPCR_STRB:
				if (!p0_done_i)
					state_next = S_WEPCR_WAIT;
			S_WEPCR_WAIT:
				if (p0_done_i)
					state_next = S_RCTRL_STRB;
			S_RCTRL_STRB:
				if (!p0_done_i)
					state_next = S_RCTRL_WAIT;
			S_RCTRL_WAIT:
				if (p0_done_i)
					state_next = S_WCTRL_STRB;
			S_WCTRL_STRB:
				if (!p0_done_i)
					state_next = S_WCTRL_WAIT;
			S_WCTRL_WAIT:
				if (p0_done_i)
					state_next = S_IDLE;
			S_IDLE:
				state_next = req_sync ? S_HOST_ACCESS : S_READ_STRB;
			S_HOST_ACCESS:
				if (!req_sync)
					state_next = S_IDLE;
			S_READ_STRB:
				if (!p0_done_i && !p1_done_i)
					state_next = S_READ_WAIT;
			S_READ_WAIT:
				if (p0_done_i && p1_done_i)
					state_next = S_READ_LATCH;
			S_READ_LATCH:
				state_next = S_SELECT;
			S_SELECT:
				state_next = S_IDLE;
			default:
				state_next = S_INIT;
		endcase
	end

	// One pulse on entry to a strobe state
	assign new_strobe = state_next != state && state_next inside {S_REPCR_STRB,
		S_WEPCR_STRB, S_RCTRL_STRB, S_WCTRL_STRB, S_READ_STRB};

	always_ff @(posedge clk) begin
		if (new_strobe) begin
			case (state_next)
				S_REPCR_STRB: frame_o <= make_frame(OP_READ, REG_EPCR, 16'h0);
				S_WEPCR_STRB: frame_o <= make_frame(OP_WRITE, REG_EPCR,
					p0_rd_data_i | EPCR_DELAY_SET);
				S_RCTRL_STRB: frame_o <= make_frame(OP_READ, REG_CTRL, 16'h0);
				S_WCTRL_STRB: frame_o <= make_frame(OP_WRITE, REG_CTRL,
					p0_rd_data_i | CTRL_RESET_SET);
				default:      frame_o <= make_frame(OP_READ, REG_PSSR, 16'h0);
			endcase
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			init_timer    <= '0;
			start_o       <= 1'b0;
			mdio_gnt_o    <= 1'b0;
			link_change_o <= 1'b0;
			link_o        <= '0;
			phy0_status_o <= '0;
			phy1_status_o <= '0;
		end else begin
			start_o       <= new_strobe;
			link_change_o <= 1'b0;
			case (state_next)
				S_INIT:
					init_timer <= init_timer + 1'b1;
				S_IDLE:
					mdio_gnt_o <= 1'b0;
				S_HOST_ACCESS:
					mdio_gnt_o <= 1'b1;
				S_READ_LATCH: begin
					phy0_status_o <= decode_pssr(p0_rd_data_i);
					phy1_status_o <= decode_pssr(p1_rd_data_i);
				end
				S_SELECT: begin
					if (link_o.up) begin
						if (!phy0_status_o.up && !phy1_status_o.up) begin
							link_o        <= '0; // Both lost
							link_change_o <= 1'b1;
						end else if (link_o.active_port && phy0_status_o.up) begin
							link_o        <= to_link(phy0_status_o, 1'b0); // Port 0 wins back
							link_change_o <= phy0_status_o.speed != link_o.speed ||
								phy0_status_o.duplex != link_o.duplex;
						end else if (!link_o.active_port && !phy0_status_o.up) begin
							link_o        <= to_link(phy1_status_o, 1'b1);
							link_change_o <= phy1_status_o.speed != link_o.speed ||
								phy1_status_o.duplex != link_o.duplex;
						end
					end else if (phy0_status_o.up) begin
						link_o        <= to_link(phy0_status_o, 1'b0);
						link_change_o <= 1'b1;
					end else if (phy1_status_o.up) begin
						link_o        <= to_link(phy1_status_o, 1'b1);
						link_change_o <= 1'b1;
					end
				end
				default: begin
				end
			endcase
		end
	end

endmodule

//--- src/gmii_port_mux.sv
`timescale 1ns/1ps

module gmii_port_mux import phy_link_pkg::*; (
	input  logic     select_i,
	input  gmii_rx_t phy0_rx_i,
	input  gmii_rx_t phy1_rx_i,
	output gmii_rx_t mac_rx_o,
	input  gmii_tx_t mac_tx_i,
	output gmii_tx_t phy0_tx_o,
	output gmii_tx_t phy1_tx_o,
	input  logic     phy0_rxclk_i,
	input  logic     phy1_rxclk_i,
	output logic     mac_rxclk_o,
	input  logic     mac_txclk_i,
	output logic     phy0_txclk_o,
	output logic     phy1_txclk_o
);

	assign mac_rx_o    = select_i ? phy1_rx_i : phy0_rx_i;
	assign mac_rxclk_o = select_i ? phy1_rxclk_i : phy0_rxclk_i;

	// Standby port sees an idle transmitter
	assign phy0_tx_o = select_i ? '0 : mac_tx_i;
	assign phy1_tx_o = select_i ? mac_tx_i : '0;

	assign phy0_txclk_o = mac_txclk_i; // Both PHYs keep a running TX clock
	assign phy1_txclk_o = mac_txclk_i;

endmodule

//--- src/mdio_shifter.sv
`timescale 1ns/1ps

module mdio_shifter import mdio_pkg::*; #(
	parameter int MDC_DIV = 4
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        start_i,
	input  mdio_frame_t frame_i,
	output logic        done_o,
	output logic [15:0] rd_data_o,
	output logic        mdc_o,
	input  logic        mdio_i,
	output logic        mdio_o,
	output logic        mdio_oe_o
);

	localparam int DIV_W = $clog2(MDC_DIV + 1);

	logic             busy;
	logic [DIV_W-1:0] div_cnt;
	logic             mdc;
	logic [5:0]       bit_cnt;
	logic [63:0]      shreg;
	logic             rd_op;
	logic [15:0]      rd_shift;
	logic             half_end;

	assign half_end = div_cnt == DIV_W'(MDC_DIV - 1);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy    <= 1'b0;
			div_cnt <= '0;
			mdc     <= 1'b0;
			bit_cnt <= '0;
		end else if (!busy) begin
			if (start_i) begin
				busy    <= 1'b1;
				div_cnt <= '0;
				mdc     <= 1'b0;
				bit_cnt <= '0;
			end
		end else if (half_end) begin
			div_cnt <= '0;
			mdc     <= !mdc;
			if (mdc) begin
				bit_cnt <= bit_cnt + 6'd1;
				if (bit_cnt == 6'd63)
					busy <= 1'b0; // Last falling edge closes the frame
			end
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// 32 preamble ones, then the frame
	always_ff @(posedge clk) begin
		if (!busy && start_i) begin
			shreg <= {32'hffff_ffff, frame_i};
			rd_op <= frame_i.op == OP_READ;
		end else if (busy && half_end && mdc) begin
			shreg <= {shreg[62:0], 1'b1};
		end
		if (busy && half_end && !mdc && rd_op && bit_cnt >= 6'd48)
			rd_shift <= {rd_shift[14:0], mdio_i}; // Rising MDC
	end

	assign done_o    = !busy;
	assign rd_data_o = rd_shift;
	assign mdc_o     = mdc;
	assign mdio_o    = busy ? shreg[63] : 1'b1;

	// Bus released from turnaround on for reads
	assign mdio_oe_o = busy && !(rd_op && bit_cnt >= 6'd46);

endmodule

//--- verif/mdio_phy_model.sv
`timescale 1ns/1ps

module mdio_phy_model import mdio_pkg::*; #(
	parameter logic [4:0] ADDR = 5'd0
) (
	input  logic mdc_i,
	input  logic mdio_i,
	input  logic mdio_oe_i,
	output logic mdio_o
);

	logic [15:0] reg_ctrl;
	logic [15:0] reg_pssr;
	logic [15:0] reg_epcr;
	logic [20:0] wr_log [0:3]; // {reg, data} per write, oldest first
	int          wr_count = 0;
	int          ones = 0;
	int          pos = 0; // Bits seen after the preamble, 0 while hunting
	logic [31:0] sh;
	logic [13:0] hdr;
	logic [15:0] rd_word;

	initial mdio_o = 1'b1;

	function automatic logic [15:0] read_reg(logic [4:0] addr);
		case (addr)
			REG_CTRL: return reg_ctrl;
			REG_PSSR: return reg_pssr;
			REG_EPCR: return reg_epcr;
			default:  return 16'hffff;
		endcase
	endfunction

	always @(posedge mdc_i) begin
		if (pos == 0) begin
			if (mdio_oe_i && !mdio_i && ones >= 32) begin
				pos = 1; // First start bit
				sh  = '0;
			end
			ones = (mdio_oe_i && mdio_i) ? ones + 1 : 0;
		end else begin
			sh  = {sh[30:0], mdio_i};
			pos = pos + 1;
			if (pos == 14) begin
				hdr     = sh[13:0]; // st, op, phy, reg
				rd_word = read_reg(hdr[4:0]);
			end
			if (hdr[11:10] == OP_READ && hdr[9:5] == ADDR && pos >= 16 && pos < 32)
				mdio_o = rd_word[31 - pos];
			if (pos == 32) begin
				if (hdr[11:10] == OP_WRITE && hdr[9:5] == ADDR) begin
					case (hdr[4:0])
						REG_CTRL: reg_ctrl = sh[15:0];
						REG_PSSR: reg_pssr = sh[15:0];
						REG_EPCR: reg_epcr = sh[15:0];
						default: ;
					endcase
					if (wr_count < 4)
						wr_log[wr_count] = {hdr[4:0], sh[15:0]};
					wr_count = wr_count + 1;
				end
				pos    = 0;
				ones   = 0;
				mdio_o = 1'b1; // Pull-up
			end
		end
	end

endmodule

//--- verif/phy_ft_golden.txt
# p0_pssr p1_pssr up speed duplex active_port change, all hex
# speed 0 is 10M, 1 is 100M, 2 is 1000M; one scenario per line, run in order
0000 0000 0 0 0 0 0
0000 6400 1 1 1 1 1
A400 6400 1 2 1 0 1
A40C 8400 1 2 1 0 0
A000 8400 1 2 0 1 1
0000 0000 0 0 0 0 1
2400 0400 1 0 1 0 1
0000 2400 1 0 1 1 0
2400 2400 1 0 1 0 0
6400 0000 1 0 1 0 0
0000 4400 1 1 0 1 1
0000 0000 0 0 0 0 1
0000 A400 1 2 1 1 1
8400 A400 1 2 0 0 1
8400 0000 1 2 0 0 0
0000 0000 0 0 0 0 1
4400 4400 1 1 0 0 1
0400 6400 1 1 0 0 0

//--- verif/phy_ft_tb.sv
`timescale 1ns/1ps

module phy_ft_tb import phy_link_pkg::*; ();

	localparam logic [4:0]  PHY_ADDR     = 5'd3;
	localparam int          MDC_DIV      = 2;
	localparam int          INIT_CYCLES  = 16;
	localparam int          FRAME_CYCLES = 128 * MDC_DIV;
	localparam int          POLL_CYCLES  = FRAME_CYCLES + 8; // Idle, strobe, latch, select, slack
	localparam logic [15:0] EPCR0        = 16'h0c60;
	localparam logic [15:0] CTRL0        = 16'h1140;

	typedef struct packed {
		logic [15:0] w0;
		logic [15:0] w1;
		link_state_t link;
		logic        change;
	} scenario_t;

	logic        clk = 1'b0;
	logic        reset, reset_in;
	link_state_t link;
	logic        link_change;
	phy_status_t phy0_status, phy1_status;
	gmii_rx_t    mac_rx, phy0_rx, phy1_rx;
	gmii_tx_t    mac_tx, phy0_tx, phy1_tx;
	logic        mac_rxclk, mac_txclk, phy0_rxclk, phy1_rxclk, phy0_txclk, phy1_txclk;
	logic        host_mdc, host_mdio, host_oe, mdio_req, mdio_gnt, host_mdio_in, irq;
	logic        phy0_mdc, phy0_mdio_in, phy0_mdio, phy0_oe, phy0_int, phy0_rst;
	logic        phy1_mdc, phy1_mdio_in, phy1_mdio, phy1_oe, phy1_int, phy1_rst;

	scenario_t   scen [$];
	int          errors = 0;
	int          watch_cycles = 0;
	int          change_count = 0;
	logic        change_prev = 1'b0;

	always #2 clk = ~clk;

	phy_ft #(
		.PHY_ADDR(PHY_ADDR), .MDC_DIV(MDC_DIV), .INIT_CYCLES(INIT_CYCLES), .INIT_EPCR(1'b1)
	) dut_i (
		.clk(clk), .reset(reset), .reset_in_i(reset_in),
		.link_o(link), .link_change_o(link_change),
		.phy0_status_o(phy0_status), .phy1_status_o(phy1_status),
		.mac_rx_o(mac_rx), .mac_tx_i(mac_tx), .mac_rxclk_o(mac_rxclk), .mac_txclk_i(mac_txclk),
		.mdc_i(host_mdc), .mdio_o_i(host_mdio), .mdio_oe_i(host_oe), .mdio_req_i(mdio_req),
		.mdio_gnt_o(mdio_gnt), .mdio_i_o(host_mdio_in), .irq_o(irq),
		.phy0_rx_i(phy0_rx), .phy0_tx_o(phy0_tx), .phy0_rxclk_i(phy0_rxclk),
		.phy0_txclk_o(phy0_txclk), .phy0_mdc_o(phy0_mdc), .phy0_mdio_i(phy0_mdio_in),
		.phy0_mdio_o(phy0_mdio), .phy0_mdio_oe_o(phy0_oe), .phy0_int_i(phy0_int),
		.phy0_reset_o(phy0_rst),
		.phy1_rx_i(phy1_rx), .phy1_tx_o(phy1_tx), .phy1_rxclk_i(phy1_rxclk),
		.phy1_txclk_o(phy1_txclk), .phy1_mdc_o(phy1_mdc), .phy1_mdio_i(phy1_mdio_in),
		.phy1_mdio_o(phy1_mdio), .phy1_mdio_oe_o(phy1_oe), .phy1_int_i(phy1_int),
		.phy1_reset_o(phy1_rst)
	);

	mdio_phy_model #(.ADDR(PHY_ADDR)) phy0_i (
		.mdc_i(phy0_mdc), .mdio_i(phy0_mdio), .mdio_oe_i(phy0_oe), .mdio_o(phy0_mdio_in)
	);

	mdio_phy_model #(.ADDR(PHY_ADDR)) phy1_i (
		.mdc_i(phy1_mdc), .mdio_i(phy1_mdio), .mdio_oe_i(phy1_oe), .mdio_o(phy1_mdio_in)
	);

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		errors++;
		$display("mismatch %s: expected %0h, actual %0h", name, exp, act);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("error: %s", what);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	// up is bit 10, speed bits 15:14, duplex bit 13
	function automatic phy_status_t status_of(logic [15:0] w);
		return phy_status_t'({w[10], w[15:13]});
	endfunction

	function automatic link_state_t next_link(link_state_t cur, phy_status_t s0,
			phy_status_t s1);
		if (!cur.up)
			return s0.up ? link_state_t'({s0, 1'b0}) : s1.up ? link_state_t'({s1, 1'b1}) : cur;
		if (!s0.up && !s1.up)
			return '0;
		if (cur.active_port == s0.up) // Port 1 with PHY 0 back, or port 0 with PHY 0 lost
			return s0.up ? link_state_t'({s0, 1'b0}) : link_state_t'({s1, 1'b1});
		return cur;
	endfunction

	task automatic check_datapath(input logic port);
		gmii_tx_t tx;
		gmii_rx_t rx0;
		gmii_rx_t rx1;
		repeat (4) begin
			tx  = gmii_tx_t'({8'($urandom), 2'b10});
			rx0 = gmii_rx_t'({8'($urandom), 4'b1010});
			rx1 = gmii_rx_t'({~rx0.dat, 4'b1100});
			@(posedge clk);
			mac_tx    <= tx;
			phy0_rx   <= rx0;
			phy1_rx   <= rx1;
			mac_txclk <= !mac_txclk;
			@(negedge clk);
			assert ((port ? phy1_tx : phy0_tx) == tx)
				else report_mismatch("tx active port", tx, port ? phy1_tx : phy0_tx);
			assert ((port ? phy0_tx : phy1_tx) == '0)
				else report_mismatch("tx standby port", 0, port ? phy0_tx : phy1_tx);
			assert (mac_rx == (port ? rx1 : rx0))
				else report_mismatch("rx to mac", port ? rx1 : rx0, mac_rx);
			assert (mac_rxclk == port && irq == port)
				else report_error("receive clock or interrupt not from the active port");
			assert (phy0_txclk == mac_txclk && phy1_txclk == mac_txclk)
				else report_error("transmit clock not passed to both PHYs");
		end
	endtask

	task automatic host_access(input logic port);
		logic b;
		@(posedge clk);
		mdio_req <= 1'b1;
		while (!mdio_gnt)
			@(negedge clk);
		repeat (8) begin
			b = 1'($urandom);
			@(posedge clk);
			host_mdc      <= !host_mdc;
			host_mdio     <= 1'($urandom);
			host_oe       <= 1'($urandom);
			phy0_i.mdio_o <= b; // PHYs answer with opposite bits
			phy1_i.mdio_o <= !b;
			@(negedge clk);
			assert (phy0_mdc == host_mdc && phy1_mdc == host_mdc)
				else report_error("PHY MDC does not follow the host MDC while granted");
			assert (phy0_mdio == host_mdio && phy1_mdio == host_mdio)
				else report_error("PHY MDIO does not follow the host while granted");
			assert (phy0_oe == host_oe && phy1_oe == host_oe)
				else report_error("PHY MDIO enable does not follow the host while granted");
			assert (host_mdio_in == (port ? !b : b))
				else report_mismatch("mdio to host", port ? !b : b, host_mdio_in);
		end
		@(posedge clk);
		mdio_req      <= 1'b0;
		host_mdc      <= 1'b0;
		host_oe       <= 1'b0;
		phy0_i.mdio_o <= 1'b1;
		phy1_i.mdio_o <= 1'b1;
		while (mdio_gnt)
			@(negedge clk);
	endtask

	always @(negedge clk) begin
		assert (!(link_change && change_prev))
			else report_error("link_change_o high for two cycles in a row");
		if (link_change === 1'b1)
			change_count++;
		change_prev = link_change;
	end

	initial begin
		wait (watch_cycles != 0);
		repeat (watch_cycles) @(posedge clk);
		$display("error: timeout after %0d cycles", watch_cycles);
		$display("CHECKS FAILED");
		$fatal(1);
	end

	initial begin
		int          fd;
		int          f [7];
		int          pulses;
		string       line;
		scenario_t   sc;
		phy_status_t s0, s1;
		link_state_t nxt;
		link_state_t model_link;
		logic        exp_change;
		void'($urandom(18316));
		reset = 1'b1;
		reset_in = 1'b0;
		mac_tx = '0;
		mac_txclk = 1'b0;
		phy0_rx = '0;
		phy1_rx = '0;
		phy0_rxclk = 1'b0;
		phy1_rxclk = 1'b1;
		phy0_int = 1'b0;
		phy1_int = 1'b1;
		host_mdc = 1'b0;
		host_mdio = 1'b1;
		host_oe = 1'b0;
		mdio_req = 1'b0;
		phy0_i.reg_epcr = EPCR0;
		phy0_i.reg_ctrl = CTRL0;
		phy0_i.reg_pssr = 16'h0;
		phy1_i.reg_epcr = 16'h0000;
		phy1_i.reg_ctrl = 16'h3100;
		phy1_i.reg_pssr = 16'h0;
		model_link = '0;

		fd = $fopen("verif/phy_ft_golden.txt", "r");
		if (fd == 0)
			report_error("cannot open verif/phy_ft_golden.txt");
		while ($fgets(line, fd))
			if ($sscanf(line, "%h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5],
					f[6]) == 7)
				scen.push_back({f[0][15:0], f[1][15:0], f[2][0], f[3][1:0], f[4][0], f[5][0],
					f[6][0]});
		$fclose(fd);
		watch_cycles = 4 + INIT_CYCLES + 4 * FRAME_CYCLES + (scen.size() + 2) * 3 * POLL_CYCLES;

		@(negedge clk);
		assert (phy0_rst && phy1_rst)
			else report_error("PHY reset not asserted while reset is high");
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		// Init read-modify-write of EPCR then CTRL
		wait (phy0_i.wr_count >= 2 && phy1_i.wr_count >= 2);
		@(negedge clk);
		assert (!phy0_rst && !phy1_rst)
			else report_error("PHY reset still asserted after reset release");
		assert (phy0_i.wr_count == 2) else report_mismatch("init writes", 2, phy0_i.wr_count);
		assert (phy0_i.wr_log[0] == {5'd20, EPCR0 | (16'd1 << 7) | (16'd1 << 1)})
			else report_mismatch("init epcr write", {5'd20, EPCR0 | 16'h0082}, phy0_i.wr_log[0]);
		assert (phy0_i.wr_log[1] == {5'd0, CTRL0 | (16'd1 << 15)})
			else report_mismatch("init ctrl write", {5'd0, CTRL0 | 16'h8000}, phy0_i.wr_log[1]);
		// PHY 1 sees the same shared frames
		assert (phy1_i.wr_log[0] == phy0_i.wr_log[0] && phy1_i.wr_log[1] == phy0_i.wr_log[1])
			else report_error("PHY 1 init writes differ from the PHY 0 frames");

		foreach (scen[i]) begin
			sc = scen[i];
			@(negedge clk);
			phy0_i.reg_pssr = sc.w0;
			phy1_i.reg_pssr = sc.w1;
			s0 = status_of(sc.w0);
			s1 = status_of(sc.w1);
			nxt = next_link(model_link, s0, s1);
			exp_change = nxt.up != model_link.up || (nxt.active_port != model_link.active_port &&
				(nxt.speed != model_link.speed || nxt.duplex != model_link.duplex));
			model_link = nxt;
			assert ({nxt, exp_change} == {sc.link, sc.change})
				else report_mismatch($sformatf("golden line %0d", i), {nxt, exp_change},
					{sc.link, sc.change});
			pulses = change_count;
			repeat (2 * POLL_CYCLES) @(negedge clk);
			assert (link == nxt)
				else report_mismatch($sformatf("scenario %0d link", i), nxt, link);
			assert (phy0_status == s0)
				else report_mismatch($sformatf("scenario %0d phy0", i), s0, phy0_status);
			assert (phy1_status == s1)
				else report_mismatch($sformatf("scenario %0d phy1", i), s1, phy1_status);
			assert (change_count - pulses == int'(exp_change))
				else report_mismatch($sformatf("scenario %0d change pulses", i), exp_change,
					change_count - pulses);
			check_datapath(nxt.active_port);
			if (i == scen.size() / 2)
				host_access(nxt.active_port); // Later scenarios show polling is back
		end

		@(posedge clk);
		reset_in <= 1'b1;
		@(negedge clk);
		assert (phy0_rst && phy1_rst && link == '0)
			else report_error("reset_in_i does not reset the PHYs and the link");

		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule
